// File: dv/pipeCoreTb.sv
// Testbench for the pipeline core, driving a file-based instruction stream
`timescale 1ns/100ps

module pipeCoreTb;
    import pipePkg::*;

    localparam int    resetCycles = 8;
    localparam int    drainLimit  = 200;
    localparam string inputFile   = "dv/programInput.txt";

    logic                  clk;
    logic                  rstN;
    logic                  instValid;
    logic [XLEN-1:0]       instWord;
    logic                  retireValid;
    logic [REG_ADDR_W-1:0] retireRd;
    logic [XLEN-1:0]       retireData;

    logic [31:0]     rngState;
    logic [XLEN-1:0] wordQ[$];
    int              gapQ[$];
    bit              fileError;
    bit              timedOut;

    pipeCore DUT (.*);

    retireChecker uChecker (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Instruction lines go to the stimulus queues, expected records to the checker
    task automatic loadProgram();
        int              fd;
        int              n;
        int              gap;
        int              rd;
        string           line;
        string           name;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] data;
        fd = $fopen(inputFile, "r");
        if (fd == 0) begin
            $display("ERROR cannot open stimulus file %s", inputFile);
            fileError = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%h %d %s %d %h", word, gap, name, rd, data);
            if (n >= 2) begin
                wordQ.push_back(word);
                gapQ.push_back(gap);
            end
            if (n == 5) uChecker.pushExpected(name, rd[REG_ADDR_W-1:0], data);
        end
        $fclose(fd);
    endtask

    initial begin
        int extra;
        int waitCycles;
        instValid = 1'b0;
        instWord  = '0;
        rstN      = 1'b0;
        rngState  = 32'd52;
        fileError = 1'b0;
        timedOut  = 1'b0;
        loadProgram();
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);   // One idle cycle before the stream
        foreach (wordQ[i]) begin
            instValid = 1'b1;
            instWord  = wordQ[i];
            @(negedge clk);
            instValid = 1'b0;
            instWord  = '0;
            rngState  = xorshift32(rngState);
            extra     = rngState % 3;
            repeat (gapQ[i] + extra) @(negedge clk);
        end
        waitCycles = 0;
        while (uChecker.pendingCount() > 0 && waitCycles < drainLimit) begin
            @(posedge clk);
            waitCycles++;
        end
        if (uChecker.pendingCount() > 0) begin
            timedOut = 1'b1;
            $display("ERROR timed out waiting for retire strobes, tests never retired:");
            uChecker.reportMissing();
        end
        repeat (6) @(posedge clk);   // Catch stray strobes after the last record
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 uChecker.passCount + uChecker.failCount + uChecker.pendingCount(),
                 uChecker.passCount, uChecker.failCount, DUT.uAsserts.failCount);
        if (!timedOut && !fileError && uChecker.passCount > 0 && uChecker.failCount == 0
                && DUT.uAsserts.failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/pipeCore_asserts.sv
// Concurrent assertions on retire behavior of the pipeline core
`timescale 1ns/100ps

module pipeCoreAsserts (
    input logic                           clk,
    input logic                           rstN,
    input logic                           instValid,
    input logic [pipePkg::XLEN-1:0]       instWord,
    input logic                           retireValid,
    input logic [pipePkg::REG_ADDR_W-1:0] retireRd
);
    import pipePkg::*;

    int failCount = 0;

    // Supported encodings that write a nonzero rd
    function automatic logic writesRd(input logic [XLEN-1:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[11:7] == 5'd0) return 1'b0;
        case (w[6:0])
            OP_R:    return (f7 == 7'h00 && f3 inside {3'd0, 3'd2, 3'd4, 3'd6, 3'd7})
                         || (f7 == 7'h20 && f3 == 3'd0);
            OP_I:    return f3 inside {3'd0, 3'd4, 3'd6, 3'd7};
            OP_LUI:  return 1'b1;
            OP_LOAD: return f3 == 3'd2;
            default: return 1'b0;
        endcase
    endfunction

    quietInReset: assert property (@(posedge clk) !rstN |-> !retireValid)
        else begin
            $error("retireValid high while reset is asserted");
            failCount++;
        end

    noZeroRd: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireRd != '0)
        else begin
            $error("retire strobe reports x0 as destination");
            failCount++;
        end

    // Sampled at N, retire is seen at edge N+4
    retireLatency: assert property (@(posedge clk) disable iff (!rstN)
        instValid && writesRd(instWord) |-> ##4 retireValid)
        else begin
            $error("register-writing instruction did not retire 4 cycles after issue");
            failCount++;
        end

endmodule

bind pipeCore pipeCoreAsserts uAsserts (.*);

// File: dv/programInput.txt
# Columns: instruction word (hex), minimum idle cycles after it, then an optional
# expected retire record: test name, rd, data (hex); text after that is ignored
002081B3 0 resetZero 3 00000000  add x3, x1, x2
FFB00093 0 addiNeg 1 FFFFFFFB    addi x1, x0, -5
00700113 0 addiPos 2 00000007    addi x2, x0, 7
00208233 0 add 4 00000002        add x4, x1, x2
401102B3 0 sub 5 0000000C        sub x5, x2, x1
0020F333 0 and 6 00000003        and x6, x1, x2
0020E3B3 0 or 7 FFFFFFFF         or x7, x1, x2
0020C433 0 xor 8 FFFFFFFC        xor x8, x1, x2
0020A4B3 0 sltNeg 9 00000001     slt x9, x1, x2
00112533 0 sltPos 10 00000000    slt x10, x2, x1
FFE17593 0 andiNeg 11 00000006   andi x11, x2, -2
FF016613 0 oriNeg 12 FFFFFFF7    ori x12, x2, -16
FFF14693 0 xoriNeg 13 FFFFFFF8   xori x13, x2, -1
12345737 0 lui 14 12345000       lui x14, 0x12345
67870793 0 fwdLui 15 12345678    addi x15, x14, 0x678
40E78833 0 fwdDist12 16 00000678 sub x16, x15, x14
0107C8B3 0 fwdDist21 17 12345000 xor x17, x15, x16
00F00933 0 fwdDist3 18 12345678  add x18, x0, x15
05500993 0 storeData 19 00000055 addi x19, x0, 0x55
01302623 0 # sw x19, 12(x0)
00C02A03 1 loadBack 20 00000055  lw x20, 12(x0)
014A0AB3 0 loadUse 21 000000AA   add x21, x20, x20
06300013 0 # addi x0, x0, 99
00200B33 0 x0Read 22 00000007    add x22, x0, x2
002110B3 0 # sll x1, x2, x2 is unsupported
00008BB3 0 bubbleKeep 23 FFFFFFFB add x23, x1, x0

// File: dv/retireChecker.sv
// Retire monitor comparing each retire strobe in order against expected records
`timescale 1ns/100ps

module retireChecker (
    input logic                           clk,
    input logic                           rstN,
    input logic                           retireValid,
    input logic [pipePkg::REG_ADDR_W-1:0] retireRd,
    input logic [pipePkg::XLEN-1:0]       retireData
);
    import pipePkg::*;

    string                 nameQ[$];
    logic [REG_ADDR_W-1:0] rdQ[$];
    logic [XLEN-1:0]       dataQ[$];
    int                    passCount = 0;
    int                    failCount = 0;

    task automatic pushExpected(input string name, input logic [REG_ADDR_W-1:0] rd,
                                input logic [XLEN-1:0] data);
        nameQ.push_back(name);
        rdQ.push_back(rd);
        dataQ.push_back(data);
    endtask

    function automatic int pendingCount();
        return nameQ.size();
    endfunction

    task automatic reportMissing();
        foreach (nameQ[i]) $display("  missing %s", nameQ[i]);
    endtask

    // Sampled mid-cycle
    always @(negedge clk) begin
        string                 name;
        logic [REG_ADDR_W-1:0] expRd;
        logic [XLEN-1:0]       expData;
        if (retireValid && !rstN) begin
            $display("ERROR retire strobe seen while reset is asserted");
            failCount++;
        end else if (retireValid && nameQ.size() == 0) begin
            $display("ERROR retire of x%0d = %08h with no expected record pending",
                     retireRd, retireData);
            failCount++;
        end else if (retireValid) begin
            name    = nameQ.pop_front();
            expRd   = rdQ.pop_front();
            expData = dataQ.pop_front();
            if (retireRd == expRd && retireData == expData) begin
                $display("pass %s: x%0d = %08h", name, retireRd, retireData);
                passCount++;
            end else begin
                $display("mismatch %s: expected x%0d = %08h, actual x%0d = %08h",
                         name, expRd, expData, retireRd, retireData);
                failCount++;
            end
        end
    end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the pipeCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module pipeCoreTb -Mdir obj_dir

output=$(./obj_dir/VpipeCoreTb +verilator+error+limit+100)
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// File: sources.f
verilog/pipePkg.sv
verilog/regFile.sv
verilog/instDecode.sv
verilog/aluExecute.sv
verilog/memWriteback.sv
verilog/pipeCore.sv
dv/pipeCore_asserts.sv
dv/retireChecker.sv
dv/pipeCoreTb.sv

// File: verilog/aluExecute.sv
// Execute stage with operand forwarding, the ALU and the EX/MEM register
`timescale 1ns/100ps

module aluExecute (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           exValid,
    input  pipePkg::aluOpE                 exAluOp,
    input  logic                           exAluSrc,
    input  logic                           exRegWrite,
    input  logic                           exMemRead,
    input  logic                           exMemWrite,
    input  logic [pipePkg::REG_ADDR_W-1:0] exRs1,
    input  logic [pipePkg::REG_ADDR_W-1:0] exRs2,
    input  logic [pipePkg::REG_ADDR_W-1:0] exRd,
    input  logic [pipePkg::XLEN-1:0]       exRData1,
    input  logic [pipePkg::XLEN-1:0]       exRData2,
    input  logic [pipePkg::XLEN-1:0]       exImm,
    input  logic                           wbValid,
    input  logic                           wbRegWrite,
    input  logic [pipePkg::REG_ADDR_W-1:0] wbRd,
    input  logic [pipePkg::XLEN-1:0]       wbData,
    output logic                           memValid,
    output logic                           memRegWrite,
    output logic                           memMemRead,
    output logic                           memMemWrite,
    output logic [pipePkg::REG_ADDR_W-1:0] memRd,
    output logic [pipePkg::XLEN-1:0]       memAluResult,
    output logic [pipePkg::XLEN-1:0]       memStoreData
);
    import pipePkg::*;

    logic [XLEN-1:0] opA, opB, aluB, aluResult;

    // EX/MEM wins over MEM/WB; a load in EX/MEM has no data yet
    function automatic logic [XLEN-1:0] fwdOperand(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       idexVal
    );
        logic hitMem;
        logic hitWb;
        hitMem = memValid && memRegWrite && !memMemRead && (memRd != '0) && (memRd == rs);
        hitWb  = wbValid && wbRegWrite && (wbRd != '0) && (wbRd == rs);
        if (hitMem)     return memAluResult;
        else if (hitWb) return wbData;
        else            return idexVal;
    endfunction

    always_comb begin
        opA = fwdOperand(exRs1, exRData1);
        opB = fwdOperand(exRs2, exRData2);
    end

    assign aluB = exAluSrc ? exImm : opB;

    always_comb begin
        case (exAluOp)
            ALU_ADD:   aluResult = opA + aluB;
            ALU_SUB:   aluResult = opA - aluB;
            ALU_AND:   aluResult = opA & aluB;
            ALU_OR:    aluResult = opA | aluB;
            ALU_XOR:   aluResult = opA ^ aluB;
            ALU_SLT:   aluResult = {{(XLEN-1){1'b0}}, ($signed(opA) < $signed(aluB))};
            ALU_PASSB: aluResult = aluB;
            default:   aluResult = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) memValid <= 1'b0;
        else       memValid <= exValid;
    end

    always_ff @(posedge clk) begin
        memRegWrite  <= exRegWrite;
        memMemRead   <= exMemRead;
        memMemWrite  <= exMemWrite;
        memRd        <= exRd;
        memAluResult <= aluResult;
        memStoreData <= opB;   // Store data after forwarding
    end

endmodule

// File: verilog/instDecode.sv
// Decode stage holding IF/ID, generating control and immediates, and driving ID/EX
`timescale 1ns/100ps

module instDecode (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           instValid,
    input  logic [pipePkg::XLEN-1:0]       instWord,
    input  logic [pipePkg::XLEN-1:0]       rData1,
    input  logic [pipePkg::XLEN-1:0]       rData2,
    output logic [pipePkg::REG_ADDR_W-1:0] rAddr1,
    output logic [pipePkg::REG_ADDR_W-1:0] rAddr2,
    output logic                           exValid,
    output pipePkg::aluOpE                 exAluOp,
    output logic                           exAluSrc,
    output logic                           exRegWrite,
    output logic                           exMemRead,
    output logic                           exMemWrite,
    output logic [pipePkg::REG_ADDR_W-1:0] exRs1,
    output logic [pipePkg::REG_ADDR_W-1:0] exRs2,
    output logic [pipePkg::REG_ADDR_W-1:0] exRd,
    output logic [pipePkg::XLEN-1:0]       exRData1,
    output logic [pipePkg::XLEN-1:0]       exRData2,
    output logic [pipePkg::XLEN-1:0]       exImm
);
    import pipePkg::*;

    logic            ifidValid;
    logic [XLEN-1:0] ifidWord;
    opcodeE          opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI, immS, immU;
    logic            legal, aluSrc, regWrite, memRead, memWrite;
    aluOpE           aluOp;
    logic [XLEN-1:0] imm;

    // IF/ID
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) ifidValid <= 1'b0;
        else       ifidValid <= instValid;
    end

    always_ff @(posedge clk) begin
        ifidWord <= instWord;
    end

    assign opcode = opcodeE'(ifidWord[6:0]);
    assign funct3 = ifidWord[14:12];
    assign funct7 = ifidWord[31:25];
    assign rAddr1 = ifidWord[19:15];
    assign rAddr2 = ifidWord[24:20];

    assign immI = {{(XLEN-12){ifidWord[31]}}, ifidWord[31:20]};
    assign immS = {{(XLEN-12){ifidWord[31]}}, ifidWord[31:25], ifidWord[11:7]};
    assign immU = {ifidWord[31:12], 12'b0};

    always_comb begin
        legal    = 1'b0;
        aluOp    = ALU_ADD;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        imm      = immI;
        case (opcode)
            OP_R: begin
                regWrite = 1'b1;
                legal    = 1'b1;
                if (funct7 == 7'b0100000 && funct3 == 3'b000) aluOp = ALU_SUB;
                else if (funct7 != 7'b0000000)                legal = 1'b0;
                else begin
                    case (funct3)
                        3'b000:  aluOp = ALU_ADD;
                        3'b111:  aluOp = ALU_AND;
                        3'b110:  aluOp = ALU_OR;
                        3'b100:  aluOp = ALU_XOR;
                        3'b010:  aluOp = ALU_SLT;
                        default: legal = 1'b0;
                    endcase
                end
            end
            OP_I: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                legal    = 1'b1;
                case (funct3)
                    3'b000:  aluOp = ALU_ADD;
                    3'b111:  aluOp = ALU_AND;
                    3'b110:  aluOp = ALU_OR;
                    3'b100:  aluOp = ALU_XOR;
                    default: legal = 1'b0;
                endcase
            end
            OP_LUI: begin
                {legal, regWrite, aluSrc} = 3'b111;
                aluOp = ALU_PASSB;
                imm   = immU;
            end
            OP_LOAD: begin
                {regWrite, aluSrc, memRead} = 3'b111;
                legal = (funct3 == 3'b010);   // LW only
            end
            OP_STORE: begin
                {aluSrc, memWrite} = 2'b11;
                imm   = immS;
                legal = (funct3 == 3'b010);   // SW only
            end
            default: legal = 1'b0;
        endcase
    end

    // Unsupported encodings become bubbles in ID/EX
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) exValid <= 1'b0;
        else       exValid <= ifidValid && legal;
    end

    always_ff @(posedge clk) begin
        exAluOp    <= aluOp;
        exAluSrc   <= aluSrc;
        exRegWrite <= regWrite;
        exMemRead  <= memRead;
        exMemWrite <= memWrite;
        exRs1      <= rAddr1;
        exRs2      <= rAddr2;
        exRd       <= ifidWord[11:7];
        exRData1   <= rData1;
        exRData2   <= rData2;
        exImm      <= imm;
    end

endmodule

// File: verilog/memWriteback.sv
// Memory and writeback stage with data memory, MEM/WB register and retire report
`timescale 1ns/100ps

module memWriteback (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           memValid,
    input  logic                           memRegWrite,
    input  logic                           memMemRead,
    input  logic                           memMemWrite,
    input  logic [pipePkg::REG_ADDR_W-1:0] memRd,
    input  logic [pipePkg::XLEN-1:0]       memAluResult,
    input  logic [pipePkg::XLEN-1:0]       memStoreData,
    output logic                           wbValid,
    output logic                           wbRegWrite,
    output logic [pipePkg::REG_ADDR_W-1:0] wbRd,
    output logic [pipePkg::XLEN-1:0]       wbData,
    output logic                           retireValid,
    output logic [pipePkg::REG_ADDR_W-1:0] retireRd,
    output logic [pipePkg::XLEN-1:0]       retireData
);
    import pipePkg::*;

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] dmemAddr;
    logic [XLEN-1:0]        loadData;

    assign dmemAddr = memAluResult[DMEM_ADDR_W+1:2];   // Word aligned

    always_ff @(posedge clk) begin
        if (memValid && memMemWrite) begin
            dmem[dmemAddr] <= memStoreData;
        end
    end

    assign loadData = dmem[dmemAddr];

    // MEM/WB
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) wbValid <= 1'b0;
        else       wbValid <= memValid;
    end

    always_ff @(posedge clk) begin
        wbRegWrite <= memRegWrite;
        wbRd       <= memRd;
        wbData     <= memMemRead ? loadData : memAluResult;
    end

    // Writes to x0 are not reported
    assign retireValid = wbValid && wbRegWrite && (wbRd != '0);
    assign retireRd    = wbRd;
    assign retireData  = wbData;

endmodule

// File: verilog/pipeCore.sv
// Top of the four-stage RV32I subset pipeline, connecting stages and register file
`timescale 1ns/100ps

module pipeCore (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           instValid,
    input  logic [pipePkg::XLEN-1:0]       instWord,
    output logic                           retireValid,
    output logic [pipePkg::REG_ADDR_W-1:0] retireRd,
    output logic [pipePkg::XLEN-1:0]       retireData
);
    import pipePkg::*;

    // Register file read side
    logic [REG_ADDR_W-1:0] rAddr1, rAddr2;
    logic [XLEN-1:0]       rData1, rData2;

    // ID/EX
    logic                  exValid, exAluSrc, exRegWrite, exMemRead, exMemWrite;
    aluOpE                 exAluOp;
    logic [REG_ADDR_W-1:0] exRs1, exRs2, exRd;
    logic [XLEN-1:0]       exRData1, exRData2, exImm;

    // EX/MEM
    logic                  memValid, memRegWrite, memMemRead, memMemWrite;
    logic [REG_ADDR_W-1:0] memRd;
    logic [XLEN-1:0]       memAluResult, memStoreData;

    // MEM/WB
    logic                  wbValid, wbRegWrite;
    logic [REG_ADDR_W-1:0] wbRd;
    logic [XLEN-1:0]       wbData;

    instDecode uDecode (
        .*
    );

    aluExecute uExecute (
        .*
    );

    memWriteback uMemWb (
        .*
    );

    // Retire qualifier doubles as the write enable
    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rAddr1 (rAddr1),
        .rAddr2 (rAddr2),
        .rData1 (rData1),
        .rData2 (rData2),
        .wEn    (retireValid),
        .wAddr  (wbRd),
        .wData  (wbData)
    );

endmodule

// File: verilog/pipePkg.sv
// Pipeline package with shared widths, ALU operations and RV32I opcodes
package pipePkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;   // Word index taken from byte address [7:2]

    // PASSB forwards operand B for LUI
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        ALU_PASSB = 3'd6
    } aluOpE;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_I     = 7'b0010011,
        OP_LUI   = 7'b0110111,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcodeE;

endpackage

// File: verilog/regFile.sv
// Register file with 32 words, two write-through read ports and x0 tied to zero
`timescale 1ns/100ps

module regFile (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [pipePkg::REG_ADDR_W-1:0] rAddr1,
    input  logic [pipePkg::REG_ADDR_W-1:0] rAddr2,
    output logic [pipePkg::XLEN-1:0]       rData1,
    output logic [pipePkg::XLEN-1:0]       rData2,
    input  logic                           wEn,
    input  logic [pipePkg::REG_ADDR_W-1:0] wAddr,
    input  logic [pipePkg::XLEN-1:0]       wData
);
    import pipePkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wrLive;

    assign wrLive = wEn && (wAddr != '0);   // x0 never written

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-through so a read in the writeback cycle sees the new value
    assign rData1 = (wrLive && (wAddr == rAddr1)) ? wData : regs[rAddr1];
    assign rData2 = (wrLive && (wAddr == rAddr2)) ? wData : regs[rAddr2];

endmodule
